/* hw/ic_pkg.sv */
/*
 * Bus widths and vector types of the interconnect
 * Route and error responder state enums
 * Default ROM and RAM memory map
 */
`default_nettype none

package ic_pkg;

    // Bus widths
    // -------------------------------------------------
    localparam int ADDR_W = 32;                 // Byte address
    localparam int DATA_W = 32;                 // One word per beat
    localparam int STRB_W = DATA_W / 8;         // One strobe per byte

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

    // Owner of a request, kept in the tracker FIFO
    typedef enum logic [1:0] {
        ROUTE_ROM,                              // ROM port at top level
        ROUTE_RAM,                              // RAM port at top level
        ROUTE_ERR                               // Internal error responder
    } route_t;

    typedef enum logic {
        STUB_IDLE,                              // Ready for a request
        STUB_RESP                               // Holding the error response
    } stub_state_t;

    // Default memory map
    // -------------------------------------------------
    localparam addr_t DEF_ROM_MATCH = 32'h1000_0000;
    localparam addr_t DEF_ROM_MASK  = 32'hFFFF_C000;   // 16 KiB window
    localparam addr_t DEF_RAM_MATCH = 32'h2000_0000;
    localparam addr_t DEF_RAM_MASK  = 32'hFFFF_0000;   // 64 KiB window

endpackage

`default_nettype wire

/* hw/ic_bus_if.sv */
/*
 * Memory bus with req/gnt request channel
 * and recv/ack response channel
 */
`default_nettype none

interface ic_bus_if;

    // Request channel
    logic          req;                         // Request valid
    logic          wen;                         // Write enable
    ic_pkg::strb_t strb;                        // Byte write strobes
    ic_pkg::data_t wdata;                       // Write data
    ic_pkg::addr_t addr;                        // Read/write address
    logic          gnt;                         // Request accepted

    // Response channel
    logic          recv;                        // Response valid
    logic          ack;                         // Response taken
    logic          error;                       // Bus error
    ic_pkg::data_t rdata;                       // Read data

    modport host (
        output req, wen, strb, wdata, addr, ack,
        input  gnt, recv, error, rdata
    );

    modport device (
        input  req, wen, strb, wdata, addr, ack,
        output gnt, recv, error, rdata
    );

endinterface

`default_nettype wire

/* hw/ic_track_if.sv */
/*
 * Link between the route mux and the response tracker
 */
`default_nettype none

interface ic_track_if;

    logic           acc_valid;                  // Request accepted this cycle
    ic_pkg::route_t acc_route;                  // Owner of that request
    logic           rsp_done;                   // Head response delivered
    logic           head_valid;                 // A response is outstanding
    ic_pkg::route_t head_route;                 // Owner of the oldest one
    logic           ready;                      // Room for another request

    modport router (
        output acc_valid, acc_route, rsp_done,
        input  head_valid, head_route, ready
    );

    modport tracker (
        input  acc_valid, acc_route, rsp_done,
        output head_valid, head_route, ready
    );

endinterface

`default_nettype wire

/* hw/ic_addr_decode.sv */
/*
 * Address decoder
 * Mask and match compare against the ROM and RAM windows
 */
`default_nettype none

module ic_addr_decode #(
    parameter ic_pkg::addr_t ROM_MATCH = ic_pkg::DEF_ROM_MATCH,
    parameter ic_pkg::addr_t ROM_MASK  = ic_pkg::DEF_ROM_MASK,
    parameter ic_pkg::addr_t RAM_MATCH = ic_pkg::DEF_RAM_MATCH,
    parameter ic_pkg::addr_t RAM_MASK  = ic_pkg::DEF_RAM_MASK
) (
    input  wire ic_pkg::addr_t addr,            // Request address
    output ic_pkg::route_t     route            // Target that owns it
);

    logic hit_rom;                              // Inside ROM window
    logic hit_ram;                              // Inside RAM window

    assign hit_rom = (addr & ROM_MASK) == ROM_MATCH;
    assign hit_ram = (addr & RAM_MASK) == RAM_MATCH;

    // Priority select
    // -------------------------------------------------
    always_comb begin
        if (hit_rom) begin
            route = ic_pkg::ROUTE_ROM;          // ROM wins an overlap
        end else if (hit_ram) begin
            route = ic_pkg::ROUTE_RAM;
        end else begin
            route = ic_pkg::ROUTE_ERR;          // Unmapped, old AXI window too
        end
    end

endmodule

`default_nettype wire

/* hw/ic_rsp_tracker.sv */
/*
 * Response tracker
 * Circular FIFO of request owners in issue order
 * Head owner output and not-full ready flag
 */
`default_nettype none

module ic_rsp_tracker #(
    parameter int MAX_REQUESTS = 3              // Requests in flight
) (
    input  wire         g_clk,
    input  wire         rst,
    ic_track_if.tracker trk
);

    localparam int PTR_W = (MAX_REQUESTS > 1) ? $clog2(MAX_REQUESTS) : 1;
    localparam int CNT_W = $clog2(MAX_REQUESTS + 1);

    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(MAX_REQUESTS - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(MAX_REQUESTS);

    ic_pkg::route_t   owner_q [MAX_REQUESTS];   // Owner per slot
    logic [PTR_W-1:0] wr_ptr;                   // Next free slot
    logic [PTR_W-1:0] rd_ptr;                   // Oldest slot
    logic [CNT_W-1:0] count;                    // Outstanding responses
    logic             push;
    logic             pop;

    assign push = trk.acc_valid;                // Only when ready
    assign pop  = trk.rsp_done;                 // Only when head valid

    // Owner storage
    // -------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (push) begin
            owner_q[wr_ptr] <= trk.acc_route;
        end
    end

    // Pointers and count
    // -------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Idle, or push and pop together
            endcase
        end
    end

    // Status to the router
    assign trk.head_valid = (count != '0);
    assign trk.head_route = owner_q[rd_ptr];    // Qualified by head_valid
    assign trk.ready      = (count != FULL_CNT);

endmodule

`default_nettype wire

/* hw/ic_error_rsp_stub.sv */
/*
 * Error responder for unmapped addresses
 * Grants one request, then answers with error and zero data
 */
`default_nettype none

module ic_error_rsp_stub (
    input  wire      g_clk,
    input  wire      rst,
    ic_bus_if.device bus
);

    ic_pkg::stub_state_t state;                 // Current state
    ic_pkg::stub_state_t state_nxt;

    // Next state
    // -------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ic_pkg::STUB_IDLE: begin
                if (bus.req) begin
                    state_nxt = ic_pkg::STUB_RESP;  // Accepted, answer next
                end
            end
            ic_pkg::STUB_RESP: begin
                if (bus.ack) begin
                    state_nxt = ic_pkg::STUB_IDLE;  // Response taken
                end
            end
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (rst) begin
            state <= ic_pkg::STUB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // One request at a time
    assign bus.gnt   = (state == ic_pkg::STUB_IDLE);
    assign bus.recv  = (state == ic_pkg::STUB_RESP);   // Held until ack
    assign bus.error = (state == ic_pkg::STUB_RESP);
    assign bus.rdata = '0;

endmodule

`default_nettype wire

/* hw/ic_route_mux.sv */
/*
 * Request gating and grant mux toward ROM, RAM and error targets
 * Head-owner response mux and ack steering back to the CPU
 */
`default_nettype none

module ic_route_mux (
    // CPU port
    input  wire                cpu_req,
    input  wire                cpu_wen,
    input  wire ic_pkg::strb_t cpu_strb,
    input  wire ic_pkg::data_t cpu_wdata,
    input  wire ic_pkg::addr_t cpu_addr,
    output logic               cpu_gnt,
    output logic               cpu_recv,
    input  wire                cpu_ack,
    output logic               cpu_error,
    output ic_pkg::data_t      cpu_rdata,
    // ROM port
    output logic               rom_req,
    output logic               rom_wen,
    output ic_pkg::strb_t      rom_strb,
    output ic_pkg::data_t      rom_wdata,
    output ic_pkg::addr_t      rom_addr,
    input  wire                rom_gnt,
    input  wire                rom_recv,
    output logic               rom_ack,
    input  wire                rom_error,
    input  wire ic_pkg::data_t rom_rdata,
    // RAM port
    output logic               ram_req,
    output logic               ram_wen,
    output ic_pkg::strb_t      ram_strb,
    output ic_pkg::data_t      ram_wdata,
    output ic_pkg::addr_t      ram_addr,
    input  wire                ram_gnt,
    input  wire                ram_recv,
    output logic               ram_ack,
    input  wire                ram_error,
    input  wire ic_pkg::data_t ram_rdata,
    // Decoder, error target and tracker
    input  wire ic_pkg::route_t route,
    ic_bus_if.host             err_bus,
    ic_track_if.router         trk
);

    logic req_ok;                               // CPU request with tracker room
    logic sel_gnt;                              // Grant of the addressed target
    logic head_rom;                             // Head response owners
    logic head_ram;
    logic head_err;

    // Request side
    // -------------------------------------------------
    assign req_ok      = cpu_req && trk.ready;
    assign rom_req     = req_ok && (route == ic_pkg::ROUTE_ROM);
    assign ram_req     = req_ok && (route == ic_pkg::ROUTE_RAM);
    assign err_bus.req = req_ok && (route == ic_pkg::ROUTE_ERR);

    // Fields fan out to every target
    assign rom_wen       = cpu_wen;
    assign rom_strb      = cpu_strb;
    assign rom_wdata     = cpu_wdata;
    assign rom_addr      = cpu_addr;
    assign ram_wen       = cpu_wen;
    assign ram_strb      = cpu_strb;
    assign ram_wdata     = cpu_wdata;
    assign ram_addr      = cpu_addr;
    assign err_bus.wen   = cpu_wen;
    assign err_bus.strb  = cpu_strb;
    assign err_bus.wdata = cpu_wdata;
    assign err_bus.addr  = cpu_addr;

    always_comb begin
        case (route)
            ic_pkg::ROUTE_ROM: sel_gnt = rom_gnt;
            ic_pkg::ROUTE_RAM: sel_gnt = ram_gnt;
            ic_pkg::ROUTE_ERR: sel_gnt = err_bus.gnt;
            default:           sel_gnt = 1'b0;
        endcase
    end

    assign cpu_gnt       = req_ok && sel_gnt;
    assign trk.acc_valid = cpu_gnt;             // Push owner on acceptance
    assign trk.acc_route = route;

    // Response side
    // -------------------------------------------------
    assign head_rom = trk.head_valid && (trk.head_route == ic_pkg::ROUTE_ROM);
    assign head_ram = trk.head_valid && (trk.head_route == ic_pkg::ROUTE_RAM);
    assign head_err = trk.head_valid && (trk.head_route == ic_pkg::ROUTE_ERR);

    // Only the oldest owner is visible, later answers wait
    always_comb begin
        cpu_recv  = 1'b0;
        cpu_error = 1'b0;
        cpu_rdata = '0;
        if (head_rom) begin
            cpu_recv  = rom_recv;
            cpu_error = rom_error;
            cpu_rdata = rom_rdata;
        end else if (head_ram) begin
            cpu_recv  = ram_recv;
            cpu_error = ram_error;
            cpu_rdata = ram_rdata;
        end else if (head_err) begin
            cpu_recv  = err_bus.recv;
            cpu_error = err_bus.error;
            cpu_rdata = err_bus.rdata;
        end
    end

    assign rom_ack      = head_rom && cpu_ack;  // Ack to head owner only
    assign ram_ack      = head_ram && cpu_ack;
    assign err_bus.ack  = head_err && cpu_ack;
    assign trk.rsp_done = cpu_recv && cpu_ack;  // Pop the head

endmodule

`default_nettype wire

/* hw/ic_top.sv */
/*
 * Interconnect top level for one CPU data port
 * Decoder, route mux, response tracker and error responder
 */
`default_nettype none

module ic_top #(
    parameter ic_pkg::addr_t ROM_MATCH    = ic_pkg::DEF_ROM_MATCH,
    parameter ic_pkg::addr_t ROM_MASK     = ic_pkg::DEF_ROM_MASK,
    parameter ic_pkg::addr_t RAM_MATCH    = ic_pkg::DEF_RAM_MATCH,
    parameter ic_pkg::addr_t RAM_MASK     = ic_pkg::DEF_RAM_MASK,
    parameter int            MAX_REQUESTS = 3
) (
    input  wire                g_clk,
    input  wire                rst,
    // CPU port
    input  wire                cpu_req,
    input  wire                cpu_wen,
    input  wire ic_pkg::strb_t cpu_strb,
    input  wire ic_pkg::data_t cpu_wdata,
    input  wire ic_pkg::addr_t cpu_addr,
    output wire                cpu_gnt,
    output wire                cpu_recv,
    input  wire                cpu_ack,
    output wire                cpu_error,
    output wire ic_pkg::data_t cpu_rdata,
    // ROM port
    output wire                rom_req,
    output wire                rom_wen,
    output wire ic_pkg::strb_t rom_strb,
    output wire ic_pkg::data_t rom_wdata,
    output wire ic_pkg::addr_t rom_addr,
    input  wire                rom_gnt,
    input  wire                rom_recv,
    output wire                rom_ack,
    input  wire                rom_error,
    input  wire ic_pkg::data_t rom_rdata,
    // RAM port
    output wire                ram_req,
    output wire                ram_wen,
    output wire ic_pkg::strb_t ram_strb,
    output wire ic_pkg::data_t ram_wdata,
    output wire ic_pkg::addr_t ram_addr,
    input  wire                ram_gnt,
    input  wire                ram_recv,
    output wire                ram_ack,
    input  wire                ram_error,
    input  wire ic_pkg::data_t ram_rdata
);

    ic_pkg::route_t route;                      // Decoded owner of cpu_addr
    ic_bus_if       err_bus ();                 // Mux to error responder
    ic_track_if     trk ();                     // Mux to tracker

    // Instances
    // -------------------------------------------------
    ic_addr_decode #(
        .ROM_MATCH (ROM_MATCH),
        .ROM_MASK  (ROM_MASK),
        .RAM_MATCH (RAM_MATCH),
        .RAM_MASK  (RAM_MASK)
    ) u_addr_decode (
        .addr  (cpu_addr),
        .route (route)
    );

    // Port names match the top level one to one
    ic_route_mux u_route_mux (.*);

    ic_rsp_tracker #(
        .MAX_REQUESTS (MAX_REQUESTS)
    ) u_rsp_tracker (
        .g_clk (g_clk),
        .rst   (rst),
        .trk   (trk)
    );

    ic_error_rsp_stub u_error_rsp_stub (
        .g_clk (g_clk),
        .rst   (rst),
        .bus   (err_bus)
    );

endmodule

`default_nettype wire

/* sim/ic_top_asserts.sv */
/*
 * Protocol assertions on the interconnect top level
 * Exclusive target requests, stable responses, grant only on a granted request
 */
`default_nettype none

module ic_top_asserts (
    input wire                g_clk,
    input wire                rst,
    input wire                rom_req,
    input wire                ram_req,
    input wire                rom_gnt,
    input wire                ram_gnt,
    input wire                cpu_req,
    input wire                cpu_gnt,
    input wire                cpu_recv,
    input wire                cpu_ack,
    input wire                cpu_error,
    input wire ic_pkg::data_t cpu_rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    // One target at a time
    a_one_target: assert property (@(posedge g_clk) disable iff (rst)
        !(rom_req && ram_req))
        else $error("rom_req and ram_req are high together");

    // Response held while not taken
    a_rsp_stable: assert property (@(posedge g_clk) disable iff (rst)
        cpu_recv && !cpu_ack |=> cpu_recv && $stable(cpu_rdata) && $stable(cpu_error))
        else $error("Response changed before ack");

    // Requested target must have granted too
    a_gnt_on_req: assert property (@(posedge g_clk) disable iff (rst)
        cpu_gnt |-> cpu_req && (!rom_req || rom_gnt) && (!ram_req || ram_gnt))
        else $error("cpu_gnt high without cpu_req or without the target grant");

endmodule

bind ic_top ic_top_asserts u_asserts (.*);

`default_nettype wire

/* sim/tb_ic_top.sv */
/*
 * Testbench for the interconnect top level
 * ROM and RAM target models with random grant and response delays
 * Stimulus table, in-order response checks and timeout
 */
`default_nettype none

module mem_target_model #(
    parameter bit IS_RAM = 1'b0                 // 0 ROM pattern, 1 strobed RAM
) (
    input  wire                g_clk,
    input  wire                rst,
    input  wire                req,
    input  wire                wen,
    input  wire ic_pkg::strb_t strb,
    input  wire ic_pkg::data_t wdata,
    input  wire ic_pkg::addr_t addr,
    output logic               gnt,
    output logic               recv,
    input  wire                ack,
    output logic               error,
    output ic_pkg::data_t      rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    ic_pkg::data_t mem [16];                    // Small RAM, word index addr[5:2]
    ic_pkg::data_t q_data [$];                  // Pending responses in order
    int            q_due [$];                   // Cycle each one may show
    int            cyc;
    int            gnt_wait;                    // Cycles left before gnt
    int            i;
    int            b;
    ic_pkg::data_t word;

    initial begin
        gnt      = 1'b0;
        recv     = 1'b0;
        error    = 1'b0;                        // Never errors
        rdata    = '0;
        cyc      = 0;
        gnt_wait = 0;
        for (i = 0; i < 16; i++) begin
            mem[i] = 32'h0BAD_0000 + i;         // Fill tied to the word index
        end
        forever begin
            // Sample at the rising edge
            @(posedge g_clk);
            cyc = cyc + 1;
            if (rst) begin
                q_data.delete();
                q_due.delete();
                gnt_wait = 0;
            end else begin
                if (recv && ack) begin
                    void'(q_data.pop_front());  // Head response taken
                    void'(q_due.pop_front());
                end
                if (req && gnt) begin
                    if (!IS_RAM) begin
                        word = addr ^ 32'hA5A5_A5A5;
                    end else if (wen) begin
                        for (b = 0; b < ic_pkg::STRB_W; b++) begin
                            if (strb[b]) begin
                                mem[addr[5:2]][b*8 +: 8] = wdata[b*8 +: 8];
                            end
                        end
                        word = '0;              // Writes return zero
                    end else begin
                        word = mem[addr[5:2]];
                    end
                    q_data.push_back(word);
                    q_due.push_back(cyc + int'($urandom_range(4, 1)));
                    gnt_wait = int'($urandom_range(2, 0));
                end else if (req && gnt_wait > 0) begin
                    gnt_wait = gnt_wait - 1;
                end
            end
            // Drive at the falling edge
            @(negedge g_clk);
            gnt   = !rst && (gnt_wait == 0);
            recv  = (q_due.size() > 0) && (q_due[0] <= cyc);   // Stays up until ack
            rdata = recv ? q_data[0] : '0;
        end
    end

endmodule

module tb_ic_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_REQ     = 3;
    localparam int RST_CYCLES  = 8;
    localparam int N_ENTRIES   = 14;
    localparam int LIMIT       = N_ENTRIES * 12 + RST_CYCLES;
    localparam int HOLD_CYCLES = 10;            // Stalled cycles before ack resumes

    localparam ic_pkg::route_t ROM = ic_pkg::ROUTE_ROM;
    localparam ic_pkg::route_t RAM = ic_pkg::ROUTE_RAM;
    localparam ic_pkg::route_t ERR = ic_pkg::ROUTE_ERR;

    typedef struct packed {
        logic           hold;                   // Withhold ack after this one
        ic_pkg::addr_t  addr;
        logic           wen;
        ic_pkg::strb_t  strb;
        ic_pkg::data_t  wdata;
        ic_pkg::route_t route;                  // Expected owner
        logic           err;                    // Expected error
        ic_pkg::data_t  rdata;                  // Expected read data
    } entry_t;

    entry_t tbl [N_ENTRIES];

    logic          g_clk = 1'b0;
    logic          rst;
    logic          cpu_req;
    logic          cpu_wen;
    ic_pkg::strb_t cpu_strb;
    ic_pkg::data_t cpu_wdata;
    ic_pkg::addr_t cpu_addr;
    logic          cpu_ack;
    logic          hold_ack;
    wire           cpu_gnt, cpu_recv, cpu_error;
    wire ic_pkg::data_t cpu_rdata;
    wire           rom_req, rom_wen, rom_gnt, rom_recv, rom_ack, rom_error;
    wire ic_pkg::strb_t rom_strb;
    wire ic_pkg::data_t rom_wdata, rom_rdata;
    wire ic_pkg::addr_t rom_addr;
    wire           ram_req, ram_wen, ram_gnt, ram_recv, ram_ack, ram_error;
    wire ic_pkg::strb_t ram_strb;
    wire ic_pkg::data_t ram_wdata, ram_rdata;
    wire ic_pkg::addr_t ram_addr;

    int     acc_cnt   = 0;                      // Requests accepted
    int     rsp_cnt   = 0;                      // Responses delivered
    int     full_seen = 0;                      // Cycles stalled on a full tracker
    int     cycles    = 0;
    int     stall;
    int     i;
    logic   granted;

    always #2 g_clk = ~g_clk;

    ic_top #(.MAX_REQUESTS(MAX_REQ)) UUT (.*);

    mem_target_model #(.IS_RAM(1'b0)) u_rom_model (
        .g_clk(g_clk), .rst(rst), .req(rom_req), .wen(rom_wen), .strb(rom_strb),
        .wdata(rom_wdata), .addr(rom_addr), .gnt(rom_gnt), .recv(rom_recv),
        .ack(rom_ack), .error(rom_error), .rdata(rom_rdata)
    );

    mem_target_model #(.IS_RAM(1'b1)) u_ram_model (
        .g_clk(g_clk), .rst(rst), .req(ram_req), .wen(ram_wen), .strb(ram_strb),
        .wdata(ram_wdata), .addr(ram_addr), .gnt(ram_gnt), .recv(ram_recv),
        .ack(ram_ack), .error(ram_error), .rdata(ram_rdata)
    );

    task automatic check_eq(input ic_pkg::data_t got, input ic_pkg::data_t exp,
                            input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "Mismatch");
        end
    endtask

    // Random ack unless held off
    initial begin
        cpu_ack = 1'b0;
        forever begin
            @(negedge g_clk);
            cpu_ack = !hold_ack && ($urandom_range(3, 0) != 0);
        end
    end

    // Response and tracker monitor
    // -------------------------------------------------
    always @(posedge g_clk) begin
        if (!rst) begin
            if ((acc_cnt - rsp_cnt) == MAX_REQ) begin
                check_eq(32'(cpu_gnt), 32'd0, "cpu_gnt with tracker full");
                if (cpu_req) full_seen = full_seen + 1;
            end
            if (cpu_req && cpu_gnt) acc_cnt = acc_cnt + 1;
            if (cpu_recv && cpu_ack) begin
                check_eq(32'(rsp_cnt < N_ENTRIES), 32'd1, "response with none outstanding");
                check_eq(32'(cpu_error), 32'(tbl[rsp_cnt].err),
                         $sformatf("cpu_error of entry %0d", rsp_cnt));
                check_eq(cpu_rdata, tbl[rsp_cnt].rdata,
                         $sformatf("cpu_rdata of entry %0d", rsp_cnt));
                rsp_cnt = rsp_cnt + 1;
            end
        end
    end

    always @(posedge g_clk) begin
        cycles = cycles + 1;
        if (cycles > LIMIT) begin
            $display("TIMEOUT: %0d of %0d responses after %0d cycles",
                     rsp_cnt, N_ENTRIES, cycles);
            $display("Some tests failed");
            $fatal(1, "Timeout");
        end
    end

    // Stimulus
    // -------------------------------------------------
    initial begin
        void'($urandom(52172));
        // hold, addr, wen, strb, wdata, route, err, rdata
        tbl[0]  = '{1'b0, 32'h1000_0000, 1'b0, 4'hF, 32'h0, ROM, 1'b0, 32'hB5A5_A5A5};
        tbl[1]  = '{1'b0, 32'h2000_0008, 1'b1, 4'hF, 32'h1122_3344, RAM, 1'b0, 32'h0};
        tbl[2]  = '{1'b0, 32'h2000_0008, 1'b1, 4'h5, 32'hAABB_CCDD, RAM, 1'b0, 32'h0};
        tbl[3]  = '{1'b0, 32'h2000_0008, 1'b0, 4'hF, 32'h0, RAM, 1'b0, 32'h11BB_33DD};
        tbl[4]  = '{1'b0, 32'h4000_0000, 1'b0, 4'hF, 32'h0, ERR, 1'b1, 32'h0};
        tbl[5]  = '{1'b0, 32'h2000_0004, 1'b1, 4'hF, 32'hCAFE_0000, RAM, 1'b0, 32'h0};
        tbl[6]  = '{1'b0, 32'h1000_0010, 1'b0, 4'hF, 32'h0, ROM, 1'b0, 32'hB5A5_A5B5};
        tbl[7]  = '{1'b0, 32'h1000_4000, 1'b0, 4'hF, 32'h0, ERR, 1'b1, 32'h0};  // Past ROM
        tbl[8]  = '{1'b1, 32'h2000_0004, 1'b1, 4'h8, 32'h5500_0000, RAM, 1'b0, 32'h0};
        tbl[9]  = '{1'b0, 32'h2000_0004, 1'b0, 4'hF, 32'h0, RAM, 1'b0, 32'h55FE_0000};
        tbl[10] = '{1'b0, 32'h1000_3FFC, 1'b0, 4'hF, 32'h0, ROM, 1'b0, 32'hB5A5_9A59};
        tbl[11] = '{1'b0, 32'h3000_0000, 1'b1, 4'hF, 32'h1234_5678, ERR, 1'b1, 32'h0};
        tbl[12] = '{1'b0, 32'h1000_0100, 1'b0, 4'hF, 32'h0, ROM, 1'b0, 32'hB5A5_A4A5};
        tbl[13] = '{1'b0, 32'h2000_0008, 1'b0, 4'hF, 32'h0, RAM, 1'b0, 32'h11BB_33DD};

        rst       = 1'b1;
        cpu_req   = 1'b0;
        cpu_wen   = 1'b0;
        cpu_strb  = '0;
        cpu_wdata = '0;
        cpu_addr  = '0;
        hold_ack  = 1'b0;
        stall     = 0;
        repeat (RST_CYCLES) @(posedge g_clk);
        @(negedge g_clk);
        rst = 1'b0;
        @(posedge g_clk);
        check_eq(32'(cpu_recv), 32'd0, "cpu_recv after reset");
        check_eq(32'(cpu_error), 32'd0, "cpu_error after reset");

        for (i = 0; i < N_ENTRIES; i++) begin
            @(negedge g_clk);
            cpu_req   = 1'b1;                   // Stays high back-to-back
            cpu_wen   = tbl[i].wen;
            cpu_strb  = tbl[i].strb;
            cpu_wdata = tbl[i].wdata;
            cpu_addr  = tbl[i].addr;
            granted   = 1'b0;
            while (!granted) begin
                @(posedge g_clk);
                granted = cpu_gnt;
                check_eq(32'(rom_req && tbl[i].route != ROM), 32'd0, "stray rom_req");
                check_eq(32'(ram_req && tbl[i].route != RAM), 32'd0, "stray ram_req");
                if (!granted && hold_ack) begin
                    stall = stall + 1;
                    if (stall == HOLD_CYCLES) hold_ack = 1'b0;   // Resume acks
                end
            end
            check_eq(32'(rom_req), 32'(tbl[i].route == ROM), "rom_req at accept");
            check_eq(32'(ram_req), 32'(tbl[i].route == RAM), "ram_req at accept");
            // Request fields reach the ROM port whatever the route
            check_eq(32'(rom_wen), 32'(tbl[i].wen), "rom_wen at accept");
            check_eq(32'(rom_strb), 32'(tbl[i].strb), "rom_strb at accept");
            check_eq(rom_wdata, tbl[i].wdata, "rom_wdata at accept");
            check_eq(rom_addr, tbl[i].addr, "rom_addr at accept");
            if (tbl[i].hold) begin
                hold_ack = 1'b1;
                stall    = 0;
            end
        end
        @(negedge g_clk);
        cpu_req = 1'b0;

        wait (rsp_cnt == N_ENTRIES);
        check_eq(32'(full_seen > 0), 32'd1, "tracker never filled");
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hw/ic_pkg.sv
hw/ic_bus_if.sv
hw/ic_track_if.sv
hw/ic_addr_decode.sv
hw/ic_rsp_tracker.sv
hw/ic_error_rsp_stub.sv
hw/ic_route_mux.sv
hw/ic_top.sv
sim/ic_top_asserts.sv
sim/tb_ic_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the interconnect testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_ic_top -f flist.f -o sim_ic

# The log decides the result
./obj_dir/sim_ic > sim.log 2>&1 || true
cat sim.log

if grep -qx "All tests passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
